/* rtl/mlu_consts.svh */
`ifndef MLU_CONSTS_SVH
`define MLU_CONSTS_SVH

// operand and result width.
`define MLU_DATA_WIDTH 32
`define MLU_PREG_WIDTH 7
`define MLU_ROB_WIDTH 6
`define MLU_OP_WIDTH 8

// operands carry two extra bits so signed and unsigned share one datapath.
`define MLU_EXT_WIDTH 34
`define MLU_PP_COUNT 17
`define MLU_PP_WIDTH 68

// carries passed from one column to the next.
`define MLU_CARRY_WIDTH 14

`define MLU_BYPASS_COUNT 5

`endif

/* rtl/mluPkg.sv */
package mluPkg;

`include "mlu_consts.svh"

    typedef logic [`MLU_DATA_WIDTH-1:0] dataT;
    typedef logic [`MLU_PREG_WIDTH-1:0] pregT;
    typedef logic [`MLU_ROB_WIDTH-1:0] robPtrT;

    // only the three multiply kinds are decoded.
    typedef enum logic [`MLU_OP_WIDTH-1:0] {
        opMulW   = 8'h01,
        opMulHW  = 8'h02,
        opMulHWU = 8'h03
    } mluOpT;

    typedef logic [`MLU_PP_WIDTH-1:0] ppT;
    typedef ppT [`MLU_PP_COUNT-1:0] ppArrayT;
    typedef logic [`MLU_PP_COUNT-1:0] columnT;
    typedef logic [`MLU_CARRY_WIDTH-1:0] carryT;
    typedef logic [2*`MLU_DATA_WIDTH-1:0] productT;

    // one address and one data word per forwarding source.
    typedef pregT [`MLU_BYPASS_COUNT-1:0] bypassAddrT;
    typedef dataT [`MLU_BYPASS_COUNT-1:0] bypassDataT;

endpackage

/* rtl/operandBypass.sv */
`timescale 1ns/1ps
`include "mlu_consts.svh"

module operandBypass (
    input  mluPkg::dataT                 src1,
    input  mluPkg::pregT                 src1Addr,
    input  logic                         src1Renamed,
    input  mluPkg::dataT                 src2,
    input  mluPkg::pregT                 src2Addr,
    input  logic                         src2Renamed,
    input  logic [`MLU_BYPASS_COUNT-1:0] bypassValid,
    input  mluPkg::bypassAddrT           bypassAddr,
    input  mluPkg::bypassDataT           bypassData,
    output mluPkg::dataT                 op1,
    output mluPkg::dataT                 op2
);

    import mluPkg::*;

    // walks the sources from the highest index down so the lowest match is kept.
    function automatic dataT pickOperand(
        input dataT                         regData,
        input pregT                         addr,
        input logic                         renamed,
        input logic [`MLU_BYPASS_COUNT-1:0] valid,
        input bypassAddrT                   srcAddr,
        input bypassDataT                   srcData
    );
        dataT result;
        result = regData;
        for (int i = `MLU_BYPASS_COUNT - 1; i >= 0; i--) begin
            if (renamed && valid[i] && (srcAddr[i] == addr)) begin
                result = srcData[i];
            end
        end
        return result;
    endfunction

    assign op1 = pickOperand(src1, src1Addr, src1Renamed, bypassValid, bypassAddr, bypassData);
    assign op2 = pickOperand(src2, src2Addr, src2Renamed, bypassValid, bypassAddr, bypassData);

endmodule

/* rtl/boothEncoder.sv */
`timescale 1ns/1ps
`include "mlu_consts.svh"

module boothEncoder (
    input  mluPkg::dataT    op1,
    input  mluPkg::dataT    op2,
    input  mluPkg::mluOpT   op,
    output mluPkg::ppArrayT partials
);

    import mluPkg::*;

    logic                       signedOps;
    logic [`MLU_EXT_WIDTH-1:0]  ext1;
    logic [`MLU_EXT_WIDTH-1:0]  ext2;
    // multiplier with the implicit zero below bit 0.
    logic [`MLU_EXT_WIDTH:0]    recode;
    ppT                         mcand;

    // digit from minus two to plus two applied to the multiplicand.
    function automatic ppT boothTerm(input logic [2:0] triplet, input ppT value);
        ppT result;
        case (triplet)
            3'b001, 3'b010: result = value;
            3'b011:         result = value << 1;
            3'b100:         result = -(value << 1);
            3'b101, 3'b110: result = -value;
            default:        result = '0;
        endcase
        return result;
    endfunction

    assign signedOps = (op != opMulHWU);

    // the unsigned high multiply gets zero extension.
    assign ext1 = {{(`MLU_EXT_WIDTH - `MLU_DATA_WIDTH){signedOps & op1[`MLU_DATA_WIDTH-1]}}, op1};
    assign ext2 = {{(`MLU_EXT_WIDTH - `MLU_DATA_WIDTH){signedOps & op2[`MLU_DATA_WIDTH-1]}}, op2};

    assign recode = {ext1, 1'b0};
    assign mcand = {{(`MLU_PP_WIDTH - `MLU_EXT_WIDTH){ext2[`MLU_EXT_WIDTH-1]}}, ext2};

    always_comb begin
        for (int i = 0; i < `MLU_PP_COUNT; i++) begin
            partials[i] = boothTerm(recode[2*i +: 3], mcand) << (2 * i);
        end
    end

endmodule

/* rtl/columnCompressor.sv */
`timescale 1ns/1ps

module columnCompressor (
    input  mluPkg::columnT bits,
    input  mluPkg::carryT  carryIn,
    output mluPkg::carryT  carryOut,
    output logic           sum,
    output logic           carry
);

    logic [4:0] lvl1;
    logic [3:0] lvl2;
    logic [1:0] lvl3;
    logic [1:0] lvl4;
    logic       lvl5;

    // returns carry in the upper bit and sum in the lower bit.
    function automatic logic [1:0] fullAdd(input logic a, input logic b, input logic c);
        return {(a & b) | (b & c) | (a & c), a ^ b ^ c};
    endfunction

    // level 1 only sees column bits.
    assign {carryOut[0], lvl1[0]} = fullAdd(bits[2], bits[3], bits[4]);
    assign {carryOut[1], lvl1[1]} = fullAdd(bits[5], bits[6], bits[7]);
    assign {carryOut[2], lvl1[2]} = fullAdd(bits[8], bits[9], bits[10]);
    assign {carryOut[3], lvl1[3]} = fullAdd(bits[11], bits[12], bits[13]);
    assign {carryOut[4], lvl1[4]} = fullAdd(bits[14], bits[15], bits[16]);

    assign {carryOut[5], lvl2[0]} = fullAdd(carryIn[0], carryIn[1], carryIn[2]);
    assign {carryOut[6], lvl2[1]} = fullAdd(bits[0], carryIn[3], carryIn[4]);
    assign {carryOut[7], lvl2[2]} = fullAdd(bits[1], lvl1[0], lvl1[1]);
    assign {carryOut[8], lvl2[3]} = fullAdd(lvl1[2], lvl1[3], lvl1[4]);

    assign {carryOut[9], lvl3[0]} = fullAdd(lvl2[0], carryIn[5], carryIn[6]);
    assign {carryOut[10], lvl3[1]} = fullAdd(lvl2[1], lvl2[2], lvl2[3]);

    assign {carryOut[11], lvl4[0]} = fullAdd(carryIn[7], carryIn[8], carryIn[9]);
    assign {carryOut[12], lvl4[1]} = fullAdd(lvl3[0], lvl3[1], carryIn[10]);

    assign {carryOut[13], lvl5} = fullAdd(lvl4[0], lvl4[1], carryIn[11]);

    // last level feeds the carry-propagate adder.
    assign {carry, sum} = fullAdd(lvl5, carryIn[12], carryIn[13]);

endmodule

/* rtl/compressTree.sv */
`timescale 1ns/1ps
`include "mlu_consts.svh"

module compressTree (
    input  mluPkg::ppArrayT partials,
    output mluPkg::productT product
);

    import mluPkg::*;

    columnT                    columns [`MLU_PP_WIDTH];
    // entry c holds the carries into column c.
    carryT                     carryChain [`MLU_PP_WIDTH+1];
    logic [`MLU_PP_WIDTH-1:0]  sumVec;
    logic [`MLU_PP_WIDTH-1:0]  carryVec;
    logic [`MLU_PP_WIDTH-1:0]  fullSum;

    // bit c of every partial product lands in column c.
    always_comb begin
        for (int c = 0; c < `MLU_PP_WIDTH; c++) begin
            for (int r = 0; r < `MLU_PP_COUNT; r++) begin
                columns[c][r] = partials[r][c];
            end
        end
    end

    assign carryChain[0] = '0;

    genvar c;
    generate
        for (c = 0; c < `MLU_PP_WIDTH; c++) begin : gColumn
            columnCompressor i_column (
                .bits     (columns[c]),
                .carryIn  (carryChain[c]),
                .carryOut (carryChain[c+1]),
                .sum      (sumVec[c]),
                .carry    (carryVec[c])
            );
        end
    endgenerate

    // column carries weigh one bit higher than their column.
    assign fullSum = sumVec + {carryVec[`MLU_PP_WIDTH-2:0], 1'b0};
    assign product = fullSum[2*`MLU_DATA_WIDTH-1:0];

endmodule

/* rtl/mluPipeline.sv */
`timescale 1ns/1ps
`include "mlu_consts.svh"

module mluPipeline (
    input  logic            Clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            flush,
    input  logic            issueValid,
    input  logic            rdValid,
    input  mluPkg::pregT    rdAddr,
    input  mluPkg::robPtrT  robPtr,
    input  mluPkg::mluOpT   op,
    input  mluPkg::ppArrayT partialsIn,
    input  mluPkg::productT product,
    output mluPkg::ppArrayT partialsOut,
    output logic            wbValid,
    output mluPkg::pregT    wbAddr,
    output mluPkg::dataT    wbData,
    output logic            robValid,
    output mluPkg::robPtrT  robPtrOut
);

    import mluPkg::*;

    logic    s1Valid;
    logic    s1RdValid;
    pregT    s1RdAddr;
    robPtrT  s1RobPtr;
    mluOpT   s1Op;

    logic    s2Valid;
    logic    s2RdValid;
    pregT    s2RdAddr;
    robPtrT  s2RobPtr;
    mluOpT   s2Op;
    productT s2Product;

    // stall wins over flush.
    always_ff @(posedge Clk) begin
        if (reset) begin
            s1Valid   <= 1'b0;
            s1RdValid <= 1'b0;
            s1Op      <= opMulW;
            s2Valid   <= 1'b0;
            s2RdValid <= 1'b0;
            s2Op      <= opMulW;
        end else if (!stall) begin
            s1Op <= op;
            s2Op <= s1Op;
            if (flush) begin
                s1Valid   <= 1'b0;
                s1RdValid <= 1'b0;
                s2Valid   <= 1'b0;
                s2RdValid <= 1'b0;
            end else begin
                s1Valid   <= issueValid;
                s1RdValid <= issueValid & rdValid;
                s2Valid   <= s1Valid;
                s2RdValid <= s1RdValid;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!stall) begin
            partialsOut <= partialsIn;
            s1RdAddr    <= rdAddr;
            s1RobPtr    <= robPtr;
            s2RdAddr    <= s1RdAddr;
            s2RobPtr    <= s1RobPtr;
            s2Product   <= product;
        end
    end

    always_comb begin
        case (s2Op)
            opMulW:            wbData = s2Product[`MLU_DATA_WIDTH-1:0];
            opMulHW, opMulHWU: wbData = s2Product[2*`MLU_DATA_WIDTH-1:`MLU_DATA_WIDTH];
            default:           wbData = '0;
        endcase
    end

    assign wbValid   = s2RdValid;
    assign wbAddr    = s2RdAddr;
    assign robValid  = s2Valid;
    assign robPtrOut = s2RobPtr;

    // a register write is always reported to the reorder buffer as well.
    aWbImpliesRob: assert property (@(posedge Clk) disable iff (reset) wbValid |-> robValid);

    aStallValids: assert property (@(posedge Clk) disable iff (reset)
        stall |=> $stable(wbValid) && $stable(robValid));

    aStallPayload: assert property (@(posedge Clk) disable iff (reset)
        stall |=> $stable(wbAddr) && $stable(robPtrOut) && $stable(wbData));

    aValidKnown: assert property (@(posedge Clk) !reset |-> !$isunknown({wbValid, robValid}));

endmodule

/* rtl/mluTop.sv */
`timescale 1ns/1ps
`include "mlu_consts.svh"

module mluTop (
    input  logic                         Clk,
    input  logic                         reset,
    input  logic                         stall,
    input  logic                         flush,
    input  logic                         issueValid,
    input  logic                         rdValid,
    input  mluPkg::pregT                 rdAddr,
    input  mluPkg::robPtrT               robPtr,
    input  mluPkg::mluOpT                op,
    input  mluPkg::dataT                 src1,
    input  mluPkg::pregT                 src1Addr,
    input  logic                         src1Renamed,
    input  mluPkg::dataT                 src2,
    input  mluPkg::pregT                 src2Addr,
    input  logic                         src2Renamed,
    input  logic [`MLU_BYPASS_COUNT-1:0] bypassValid,
    input  mluPkg::bypassAddrT           bypassAddr,
    input  mluPkg::bypassDataT           bypassData,
    output logic                         wbValid,
    output mluPkg::pregT                 wbAddr,
    output mluPkg::dataT                 wbData,
    output logic                         robValid,
    output mluPkg::robPtrT               robPtrOut
);

    import mluPkg::*;

    dataT    op1;
    dataT    op2;
    ppArrayT partials;
    // partial products after the stage-1 register.
    ppArrayT partialsStage;
    productT product;

    operandBypass i_operandBypass (
        .src1        (src1),
        .src1Addr    (src1Addr),
        .src1Renamed (src1Renamed),
        .src2        (src2),
        .src2Addr    (src2Addr),
        .src2Renamed (src2Renamed),
        .bypassValid (bypassValid),
        .bypassAddr  (bypassAddr),
        .bypassData  (bypassData),
        .op1         (op1),
        .op2         (op2)
    );

    boothEncoder i_boothEncoder (
        .op1      (op1),
        .op2      (op2),
        .op       (op),
        .partials (partials)
    );

    mluPipeline i_mluPipeline (
        .Clk         (Clk),
        .reset       (reset),
        .stall       (stall),
        .flush       (flush),
        .issueValid  (issueValid),
        .rdValid     (rdValid),
        .rdAddr      (rdAddr),
        .robPtr      (robPtr),
        .op          (op),
        .partialsIn  (partials),
        .product     (product),
        .partialsOut (partialsStage),
        .wbValid     (wbValid),
        .wbAddr      (wbAddr),
        .wbData      (wbData),
        .robValid    (robValid),
        .robPtrOut   (robPtrOut)
    );

    // the tree sits between the two stage registers.
    compressTree i_compressTree (
        .partials (partialsStage),
        .product  (product)
    );

endmodule

/* test/mluTb.sv */
`timescale 1ns/1ps
`include "mlu_consts.svh"

module mluTb;

    import mluPkg::*;

    localparam int clkPeriod = 10;
    localparam int resetCycles = 8;
    localparam int numPairs = 20;
    localparam int numCorners = 4;
    // reset, back-to-back run, two high-word runs per operand pair, then the short tests.
    localparam int testCycles = resetCycles + (numPairs + 2)
        + 6 * (numPairs + numCorners * numCorners) + 40;

    logic                         Clk = 1'b0;
    logic                         reset;
    logic                         stall;
    logic                         flush;
    logic                         issueValid;
    logic                         rdValid;
    pregT                         rdAddr;
    robPtrT                       robPtr;
    mluOpT                        op;
    dataT                         src1;
    pregT                         src1Addr;
    logic                         src1Renamed;
    dataT                         src2;
    pregT                         src2Addr;
    logic                         src2Renamed;
    logic [`MLU_BYPASS_COUNT-1:0] bypassValid;
    bypassAddrT                   bypassAddr;
    bypassDataT                   bypassData;
    logic                         wbValid;
    pregT                         wbAddr;
    dataT                         wbData;
    logic                         robValid;
    robPtrT                       robPtrOut;

    integer seed;
    dataT   pairA [numPairs];
    dataT   pairB [numPairs];
    dataT   corners [numCorners];

    mluTop i_mluTop (
        .Clk         (Clk),
        .reset       (reset),
        .stall       (stall),
        .flush       (flush),
        .issueValid  (issueValid),
        .rdValid     (rdValid),
        .rdAddr      (rdAddr),
        .robPtr      (robPtr),
        .op          (op),
        .src1        (src1),
        .src1Addr    (src1Addr),
        .src1Renamed (src1Renamed),
        .src2        (src2),
        .src2Addr    (src2Addr),
        .src2Renamed (src2Renamed),
        .bypassValid (bypassValid),
        .bypassAddr  (bypassAddr),
        .bypassData  (bypassData),
        .wbValid     (wbValid),
        .wbAddr      (wbAddr),
        .wbData      (wbData),
        .robValid    (robValid),
        .robPtrOut   (robPtrOut)
    );

    always #(clkPeriod / 2) Clk = ~Clk;

    // full 64-bit product, operands extended as the op asks.
    function automatic dataT expectedResult(input mluOpT kind, input dataT a, input dataT b);
        logic [63:0] wideA;
        logic [63:0] wideB;
        logic [63:0] prod;
        if (kind == opMulHWU) begin
            wideA = {32'h0, a};
            wideB = {32'h0, b};
        end else begin
            wideA = {{32{a[31]}}, a};
            wideB = {{32{b[31]}}, b};
        end
        prod = wideA * wideB;
        if (kind == opMulW) begin
            return prod[31:0];
        end else begin
            return prod[63:32];
        end
    endfunction

    task automatic checkData(input string name, input dataT got, input dataT exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic checkPreg(input string name, input pregT got, input pregT exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic checkRobPtr(input string name, input robPtrT got, input robPtrT exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic driveIssue(input mluOpT kind, input dataT a, input dataT b,
                              input pregT rd, input robPtrT rob, input logic writes);
        issueValid <= 1'b1;
        rdValid    <= writes;
        op         <= kind;
        src1       <= a;
        src2       <= b;
        rdAddr     <= rd;
        robPtr     <= rob;
    endtask

    task automatic driveIdle();
        issueValid <= 1'b0;
        rdValid    <= 1'b0;
    endtask

    task automatic checkOutputs(input dataT expData, input pregT expRd, input robPtrT expRob,
                                input logic expWb);
        checkBit("robValid", robValid, 1'b1);
        checkBit("wbValid", wbValid, expWb);
        checkPreg("wbAddr", wbAddr, expRd);
        checkRobPtr("robPtrOut", robPtrOut, expRob);
        checkData("wbData", wbData, expData);
    endtask

    task automatic checkValidsLow();
        checkBit("wbValid", wbValid, 1'b0);
        checkBit("robValid", robValid, 1'b0);
    endtask

    // one multiply on its own, checked two edges after it is sampled.
    task automatic runOne(input mluOpT kind, input dataT a, input dataT b, input dataT expData,
                          input pregT rd, input robPtrT rob, input logic writes,
                          output dataT result);
        @(posedge Clk);
        driveIssue(kind, a, b, rd, rob, writes);
        @(posedge Clk);
        driveIdle();
        @(posedge Clk);
        @(negedge Clk);
        checkOutputs(expData, rd, rob, writes);
        result = wbData;
    endtask

    task automatic testLowWordBackToBack();
        for (int cyc = 0; cyc < numPairs + 2; cyc++) begin
            @(posedge Clk);
            if (cyc < numPairs) begin
                driveIssue(opMulW, pairA[cyc], pairB[cyc], pregT'(cyc + 1), robPtrT'(cyc), 1'b1);
            end else begin
                driveIdle();
            end
            @(negedge Clk);
            if (cyc >= 2) begin
                checkOutputs(expectedResult(opMulW, pairA[cyc-2], pairB[cyc-2]),
                             pregT'(cyc - 1), robPtrT'(cyc - 2), 1'b1);
            end
        end
    endtask

    task automatic testHighWord();
        dataT a;
        dataT b;
        dataT hs;
        dataT hu;
        dataT corr;
        for (int i = 0; i < numPairs + numCorners * numCorners; i++) begin
            if (i < numPairs) begin
                a = pairA[i];
                b = pairB[i];
            end else begin
                a = corners[(i - numPairs) / numCorners];
                b = corners[(i - numPairs) % numCorners];
            end
            runOne(opMulHW, a, b, expectedResult(opMulHW, a, b), pregT'(i), robPtrT'(i), 1'b1, hs);
            runOne(opMulHWU, a, b, expectedResult(opMulHWU, a, b), pregT'(i), robPtrT'(i), 1'b1, hu);
            // unsigned high word gains each operand whose partner is negative.
            corr = (a[31] ? b : '0) + (b[31] ? a : '0);
            checkData("high word difference", hu - hs, corr);
        end
    endtask

    task automatic testBypassPriority();
        dataT res;
        @(posedge Clk);
        src1Addr    <= 7'd9;
        src1Renamed <= 1'b1;
        src2Addr    <= 7'd9;
        src2Renamed <= 1'b0;
        // source 0 points elsewhere, sources 1 to 4 all match.
        bypassValid <= 5'b11111;
        bypassAddr  <= {7'd9, 7'd9, 7'd9, 7'd9, 7'd3};
        bypassData  <= {32'h0505_0505, 32'h0404_0404, 32'h0303_0303, 32'h0202_0202, 32'h0101_0101};
        runOne(opMulW, 32'hdead_beef, 32'h0000_0007, expectedResult(opMulW, 32'h0202_0202, 32'h7),
               7'd11, 6'd11, 1'b1, res);
        @(posedge Clk);
        src1Renamed <= 1'b0;
        src2Renamed <= 1'b1;
        bypassValid <= 5'b11000;
        runOne(opMulHWU, 32'h8000_0005, 32'h1234_5678,
               expectedResult(opMulHWU, 32'h8000_0005, 32'h0404_0404), 7'd12, 6'd12, 1'b1, res);
        @(posedge Clk);
        src2Renamed <= 1'b0;
        bypassValid <= '0;
    endtask

    task automatic testStall();
        dataT   heldData;
        pregT   heldAddr;
        robPtrT heldRob;
        @(posedge Clk);
        driveIssue(opMulHW, 32'h8000_0001, 32'h0000_0003, 7'd42, 6'd17, 1'b1);
        @(posedge Clk);
        // the issue is in stage 1 now, later issues must be ignored.
        stall <= 1'b1;
        driveIssue(opMulW, 32'hffff_ffff, 32'hffff_ffff, 7'd1, 6'd1, 1'b1);
        @(negedge Clk);
        heldData = wbData;
        heldAddr = wbAddr;
        heldRob  = robPtrOut;
        for (int i = 0; i < 5; i++) begin
            @(posedge Clk);
            if (i == 4) begin
                stall <= 1'b0;
                driveIdle();
            end
            @(negedge Clk);
            checkValidsLow();
            checkData("wbData", wbData, heldData);
            checkPreg("wbAddr", wbAddr, heldAddr);
            checkRobPtr("robPtrOut", robPtrOut, heldRob);
        end
        @(posedge Clk);
        @(negedge Clk);
        checkOutputs(expectedResult(opMulHW, 32'h8000_0001, 32'h0000_0003), 7'd42, 6'd17, 1'b1);
        @(posedge Clk);
        @(negedge Clk);
        checkValidsLow();
    endtask

    task automatic testFlushAndReset();
        dataT res;
        @(posedge Clk);
        driveIssue(opMulW, 32'h0000_0011, 32'h0000_0022, 7'd5, 6'd5, 1'b1);
        @(posedge Clk);
        driveIssue(opMulW, 32'h0000_0033, 32'h0000_0044, 7'd6, 6'd6, 1'b1);
        flush <= 1'b1;
        @(posedge Clk);
        flush <= 1'b0;
        driveIdle();
        repeat (3) begin
            @(negedge Clk);
            checkValidsLow();
            @(posedge Clk);
        end
        // no register write, but the reorder buffer still hears of it.
        runOne(opMulW, 32'h6, 32'h7, 32'd42, 7'd8, 6'd8, 1'b0, res);
        @(posedge Clk);
        driveIssue(opMulHWU, 32'hffff_ffff, 32'h0000_0002, 7'd9, 6'd9, 1'b1);
        @(posedge Clk);
        driveIdle();
        reset <= 1'b1;
        @(posedge Clk);
        reset <= 1'b0;
        repeat (2) begin
            @(negedge Clk);
            checkValidsLow();
            @(posedge Clk);
        end
    endtask

    initial begin
        seed        = 59;
        reset       = 1'b1;
        stall       = 1'b0;
        flush       = 1'b0;
        issueValid  = 1'b0;
        rdValid     = 1'b0;
        rdAddr      = '0;
        robPtr      = '0;
        op          = opMulW;
        src1        = '0;
        src1Addr    = '0;
        src1Renamed = 1'b0;
        src2        = '0;
        src2Addr    = '0;
        src2Renamed = 1'b0;
        bypassValid = '0;
        bypassAddr  = '0;
        bypassData  = '0;
        for (int i = 0; i < numPairs; i++) begin
            pairA[i] = $random(seed);
            pairB[i] = $random(seed);
        end
        corners[0] = 32'h0000_0000;
        corners[1] = 32'hffff_ffff;
        corners[2] = 32'h8000_0000;
        corners[3] = 32'h7fff_ffff;
        repeat (resetCycles) @(posedge Clk);
        reset <= 1'b0;
        testLowWordBackToBack();
        testHighWord();
        testBypassPriority();
        testStall();
        testFlushAndReset();
        $display("All checks passed");
        $finish;
    end

    // ends a hung run after twice the expected length plus a margin.
    initial begin
        #((testCycles * 2 + 100) * clkPeriod);
        $display("timeout: the tests did not finish in time");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* build.f */
+incdir+rtl
rtl/mluPkg.sv
rtl/operandBypass.sv
rtl/boothEncoder.sv
rtl/columnCompressor.sv
rtl/compressTree.sv
rtl/mluPipeline.sv
rtl/mluTop.sv
test/mluTb.sv

/* Makefile */
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module mluTb

sim:
	verilator --binary --timing --assert -f build.f --top-module mluTb -o mluSim
	./obj_dir/mluSim | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
